//--- design/mcu_pkg.sv
/*
 * Shared widths, interrupt bit positions, power-control structs
 * and the power-domain sequencer states
 */
package mcu_pkg;

  localparam int NUM_BANKS = 8;
  localparam int NUM_FAST_INTR = 15;

  // core interrupt id of fast line 0
  localparam int FAST_IRQ_BASE = 16;

  // standard bits in the core vector
  localparam int IRQ_SOFTWARE_BIT = 3;
  localparam int IRQ_TIMER_BIT = 7;
  localparam int IRQ_EXTERNAL_BIT = 11;

  typedef logic [31:0] intr_t;

  // timer 1..3, dma done, spi, spi flash, 8 ao gpio, ext fast line
  typedef logic [NUM_FAST_INTR-1:0] fast_intr_t;

  typedef logic [4:0] irq_id_t;
  typedef logic [NUM_BANKS-1:0] bank_mask_t;

  // all fields active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_out_t;

  typedef struct packed {
    logic pwrgate_ack_n;
  } pwr_ctrl_in_t;

  // domain fully on, nothing gated
  localparam pwr_ctrl_out_t PWR_CTRL_IDLE = '{default: 1'b1};

  typedef enum logic [3:0] {
    PWR_ON,
    PWR_CLK_OFF,
    PWR_ISO_ON,
    PWR_RST_ON,
    PWR_SW_OFF,
    PWR_OFF,
    PWR_SW_ON,
    PWR_RST_OFF,
    PWR_ISO_OFF,
    PWR_CLK_ON,
    PWR_RETAIN
  } pwr_state_e;

endpackage

//--- design/pwr_domain_fsm.sv
/*
 * Power sequencer for a single domain: clock gate, isolation,
 * reset and power switch, with optional retention parking
 */
module pwr_domain_fsm #(
  parameter bit RETENTION = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   want_on_i,
  input  logic                   ret_req_i,
  output mcu_pkg::pwr_ctrl_out_t pwr_o,
  input  mcu_pkg::pwr_ctrl_in_t  pwr_i
);

  import mcu_pkg::*;

  pwr_state_e    state_q;
  pwr_state_e    state_d;
  logic          ret_q;
  pwr_ctrl_out_t pwr_d;
  pwr_ctrl_out_t pwr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_ON: begin
        if (!want_on_i) begin
          state_d = PWR_CLK_OFF;
        end
      end
      PWR_CLK_OFF: state_d = ret_q ? PWR_RETAIN : PWR_ISO_ON;
      PWR_ISO_ON:  state_d = PWR_RST_ON;
      PWR_RST_ON:  state_d = PWR_SW_OFF;
      PWR_SW_OFF: begin
        // switch reports open
        if (!pwr_i.pwrgate_ack_n) begin
          state_d = PWR_OFF;
        end
      end
      PWR_OFF: begin
        if (want_on_i) begin
          state_d = PWR_SW_ON;
        end
      end
      PWR_SW_ON: begin
        // switch reports closed
        if (pwr_i.pwrgate_ack_n) begin
          state_d = PWR_RST_OFF;
        end
      end
      PWR_RST_OFF: state_d = PWR_ISO_OFF;
      PWR_ISO_OFF: state_d = PWR_CLK_ON;
      PWR_CLK_ON:  state_d = PWR_ON;
      PWR_RETAIN: begin
        if (want_on_i) begin
          state_d = PWR_CLK_ON;
        end
      end
      default: state_d = PWR_ON;
    endcase
  end

  // control levels for the current state, registered below
  always_comb begin
    pwr_d = PWR_CTRL_IDLE;
    if (state_q != PWR_ON) begin
      pwr_d.clkgate_en_n = 1'b0;
    end
    if (state_q inside {PWR_ISO_ON, PWR_RST_ON, PWR_SW_OFF, PWR_OFF,
                        PWR_SW_ON, PWR_RST_OFF, PWR_ISO_OFF}) begin
      pwr_d.isogate_en_n = 1'b0;
    end
    if (state_q inside {PWR_RST_ON, PWR_SW_OFF, PWR_OFF, PWR_SW_ON, PWR_RST_OFF}) begin
      pwr_d.rst_n = 1'b0;
    end
    // switch closes again as soon as SW_ON is entered so the ack can follow
    if (state_q inside {PWR_SW_OFF, PWR_OFF}) begin
      pwr_d.pwrgate_en_n = 1'b0;
    end
    if (state_q == PWR_RETAIN) begin
      pwr_d.retentive_en_n = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= PWR_ON;
      ret_q   <= 1'b0;
      pwr_q   <= PWR_CTRL_IDLE;
      // domain held in reset with the rest of the chip
      pwr_q.rst_n <= 1'b0;
    end else begin
      state_q <= state_d;
      pwr_q   <= pwr_d;
      // retention choice taken once, when the off sequence starts
      if (state_q == PWR_ON && !want_on_i) begin
        ret_q <= RETENTION && ret_req_i;
      end
    end
  end

  assign pwr_o = pwr_q;

  // isolation must already be active when the switch opens
  a_iso_before_switch : assert property (
    @(posedge clk_i) disable iff (rst_i)
    $fell(pwr_o.pwrgate_en_n) |-> !pwr_o.isogate_en_n
  );

  // a retained bank keeps its supply
  a_retain_powered : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !pwr_o.retentive_en_n |-> pwr_o.pwrgate_en_n && pwr_i.pwrgate_ack_n
  );

endmodule

//--- design/fast_irq_ctrl.sv
/*
 * Fast interrupt pending/enable logic and core interrupt vector
 */
module fast_irq_ctrl (
  input  logic                clk_i,
  input  logic                rst_i,
  input  mcu_pkg::fast_intr_t fast_src_i,
  input  mcu_pkg::fast_intr_t fast_en_i,
  input  logic                irq_software_i,
  input  logic                irq_external_i,
  input  logic                timer0_intr_i,
  input  logic                irq_ack_i,
  input  mcu_pkg::irq_id_t    irq_id_i,
  output mcu_pkg::intr_t      intr_o
);

  import mcu_pkg::*;

  fast_intr_t pending_q;
  fast_intr_t ack_clr;

  // decode ack id into a one-hot clear
  always_comb begin
    ack_clr = '0;
    if (irq_ack_i) begin
      for (int k = 0; k < NUM_FAST_INTR; k++) begin
        if (irq_id_i == irq_id_t'(FAST_IRQ_BASE + k)) begin
          ack_clr[k] = 1'b1;
        end
      end
    end
  end

  // a live source re-sets its bit, so set wins
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~ack_clr) | fast_src_i;
    end
  end

  always_comb begin
    intr_o = '0;
    intr_o[IRQ_SOFTWARE_BIT] = irq_software_i;
    intr_o[IRQ_TIMER_BIT] = timer0_intr_i;
    intr_o[IRQ_EXTERNAL_BIT] = irq_external_i;
    intr_o[FAST_IRQ_BASE +: NUM_FAST_INTR] = pending_q & fast_en_i;
  end

  // top bit is reserved in the core vector
  a_no_bit31 : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !intr_o[31]
  );

endmodule

//--- design/pwr_manager.sv
/*
 * Power manager: domain targets, CPU wake-up on interrupt,
 * per-domain sequencers and combined domain resets
 */
module pwr_manager (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  logic                                            debug_ndmreset_ni,
  input  logic                                            core_sleep_i,
  input  logic                                            cpu_pg_en_i,
  input  logic                                            periph_off_i,
  input  mcu_pkg::bank_mask_t                             bank_off_i,
  input  mcu_pkg::bank_mask_t                             bank_ret_i,
  input  mcu_pkg::intr_t                                  intr_i,
  output mcu_pkg::pwr_ctrl_out_t                          cpu_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t                          periph_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t [mcu_pkg::NUM_BANKS-1:0] bank_pwr_o,
  input  mcu_pkg::pwr_ctrl_in_t                           cpu_pwr_i,
  input  mcu_pkg::pwr_ctrl_in_t                           periph_pwr_i,
  input  mcu_pkg::pwr_ctrl_in_t  [mcu_pkg::NUM_BANKS-1:0] bank_pwr_i,
  output logic                                            cpu_rst_no,
  output logic                                            periph_rst_no
);

  import mcu_pkg::*;

  logic       cpu_want_on;
  logic       periph_want_on;
  bank_mask_t bank_want_on;

  // cpu may sleep gated only while nothing is pending
  assign cpu_want_on = !(core_sleep_i && cpu_pg_en_i && (intr_i == '0));
  assign periph_want_on = !periph_off_i;
  assign bank_want_on = ~bank_off_i;

  pwr_domain_fsm #(
    .RETENTION(1'b0)
  ) u_cpu_fsm (
    .clk_i,
    .rst_i,
    .want_on_i(cpu_want_on),
    .ret_req_i(1'b0),
    .pwr_o    (cpu_pwr_o),
    .pwr_i    (cpu_pwr_i)
  );

  pwr_domain_fsm #(
    .RETENTION(1'b0)
  ) u_periph_fsm (
    .clk_i,
    .rst_i,
    .want_on_i(periph_want_on),
    .ret_req_i(1'b0),
    .pwr_o    (periph_pwr_o),
    .pwr_i    (periph_pwr_i)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    pwr_domain_fsm #(
      .RETENTION(1'b1)
    ) u_bank_fsm (
      .clk_i,
      .rst_i,
      .want_on_i(bank_want_on[k]),
      .ret_req_i(bank_ret_i[k]),
      .pwr_o    (bank_pwr_o[k]),
      .pwr_i    (bank_pwr_i[k])
    );
  end

  // debug ndmreset resets both logic domains
  assign cpu_rst_no = cpu_pwr_o.rst_n & debug_ndmreset_ni;
  assign periph_rst_no = periph_pwr_o.rst_n & debug_ndmreset_ni;

endmodule

//--- design/mcu_ao_ctrl_top.sv
/*
 * Always-on control top: interrupt controller and power manager
 */
module mcu_ao_ctrl_top (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  logic                                            debug_ndmreset_ni,
  input  logic                                            core_sleep_i,
  input  logic                                            cpu_pg_en_i,
  input  logic                                            periph_off_i,
  input  mcu_pkg::bank_mask_t                             bank_off_i,
  input  mcu_pkg::bank_mask_t                             bank_ret_i,
  input  mcu_pkg::fast_intr_t                             fast_src_i,
  input  mcu_pkg::fast_intr_t                             fast_en_i,
  input  logic                                            irq_software_i,
  input  logic                                            irq_external_i,
  input  logic                                            timer0_intr_i,
  input  logic                                            irq_ack_i,
  input  mcu_pkg::irq_id_t                                irq_id_i,
  output mcu_pkg::intr_t                                  intr_o,
  output mcu_pkg::pwr_ctrl_out_t                          cpu_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t                          periph_pwr_o,
  input  mcu_pkg::pwr_ctrl_in_t                           cpu_pwr_i,
  input  mcu_pkg::pwr_ctrl_in_t                           periph_pwr_i,
  output mcu_pkg::pwr_ctrl_out_t [mcu_pkg::NUM_BANKS-1:0] bank_pwr_o,
  input  mcu_pkg::pwr_ctrl_in_t  [mcu_pkg::NUM_BANKS-1:0] bank_pwr_i,
  output logic                                            cpu_rst_no,
  output logic                                            periph_rst_no
);

  import mcu_pkg::*;

  // core vector, also used as the cpu wake source
  intr_t core_intr;

  fast_irq_ctrl u_fast_irq_ctrl (
    .clk_i,
    .rst_i,
    .fast_src_i,
    .fast_en_i,
    .irq_software_i,
    .irq_external_i,
    .timer0_intr_i,
    .irq_ack_i,
    .irq_id_i,
    .intr_o(core_intr)
  );

  pwr_manager u_pwr_manager (
    .clk_i,
    .rst_i,
    .debug_ndmreset_ni,
    .core_sleep_i,
    .cpu_pg_en_i,
    .periph_off_i,
    .bank_off_i,
    .bank_ret_i,
    .intr_i(core_intr),
    .cpu_pwr_o,
    .periph_pwr_o,
    .bank_pwr_o,
    .cpu_pwr_i,
    .periph_pwr_i,
    .bank_pwr_i,
    .cpu_rst_no,
    .periph_rst_no
  );

  assign intr_o = core_intr;

endmodule

//--- testbench/tb_checker.sv
/*
 * Testbench checker: per-step comparison with trace expectations
 * and power-sequence ordering rules watched every cycle
 */
module tb_checker (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  mcu_pkg::intr_t                                  intr_i,
  input  mcu_pkg::pwr_ctrl_out_t [mcu_pkg::NUM_BANKS+1:0] dom_pwr_i,
  input  mcu_pkg::pwr_ctrl_in_t  [mcu_pkg::NUM_BANKS+1:0] dom_ack_i,
  input  logic [1:0]                                      rst_n_i,
  input  logic                                            check_i,
  input  logic [8*20-1:0]                                 test_name_i,
  input  mcu_pkg::intr_t                                  exp_intr_i,
  input  logic [mcu_pkg::NUM_BANKS+1:0]                   exp_off_i,
  input  logic [mcu_pkg::NUM_BANKS+1:0]                   exp_ret_i,
  input  logic [1:0]                                      exp_rst_n_i,
  output logic                                            settled_o,
  output int                                              mismatch_cnt_o,
  output int                                              rule_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import mcu_pkg::*;

  localparam int NUM_DOM = NUM_BANKS + 2;

  pwr_ctrl_out_t [NUM_DOM-1:0] prev_q;
  int mismatches = 0;
  int rule_errs = 0;

  // domain 0 is the cpu, 1 the peripherals, then the memory banks
  function automatic string domain_name(int d);
    return (d == 0) ? "cpu" : (d == 1) ? "periph" : $sformatf("bank%0d", d - 2);
  endfunction

  // off pattern keeps only retentive_en_n high
  // retained pattern gates the clock and keeps the supply
  function automatic pwr_ctrl_out_t expected_pattern(logic off, logic ret);
    pwr_ctrl_out_t p;
    p = '1;
    if (off) begin
      p.pwrgate_en_n = 1'b0;
      p.isogate_en_n = 1'b0;
      p.rst_n = 1'b0;
      p.clkgate_en_n = 1'b0;
    end else if (ret) begin
      p.clkgate_en_n = 1'b0;
      p.retentive_en_n = 1'b0;
    end
    return p;
  endfunction

  task automatic check_order(int d, pwr_ctrl_out_t prev, pwr_ctrl_out_t cur);
    if (prev.pwrgate_en_n && !cur.pwrgate_en_n &&
        (prev.clkgate_en_n || prev.isogate_en_n || prev.rst_n)) begin
      $display("error: %0s switch opened before clock, isolation and reset were active",
               domain_name(d));
      rule_errs++;
    end
    if (!prev.pwrgate_en_n && cur.pwrgate_en_n &&
        (cur.clkgate_en_n || cur.isogate_en_n || cur.rst_n)) begin
      $display("error: %0s clock, isolation or reset released before the switch closed",
               domain_name(d));
      rule_errs++;
    end
    if (!cur.retentive_en_n && !cur.pwrgate_en_n) begin
      $display("error: %0s retention active while the switch is open", domain_name(d));
      rule_errs++;
    end
  endtask

  always_comb begin
    settled_o = 1'b1;
    for (int d = 0; d < NUM_DOM; d++) begin
      if (dom_pwr_i[d] != expected_pattern(exp_off_i[d], exp_ret_i[d]) ||
          dom_ack_i[d].pwrgate_ack_n != dom_pwr_i[d].pwrgate_en_n) begin
        settled_o = 1'b0;
      end
    end
  end

  // step results sampled mid-cycle
  always @(negedge clk_i) begin
    if (check_i) begin
      if (intr_i !== exp_intr_i) begin
        $display("Mismatch %0s intr_o expected %08h actual %08h",
                 test_name_i, exp_intr_i, intr_i);
        mismatches++;
      end
      for (int d = 0; d < NUM_DOM; d++) begin
        if (dom_pwr_i[d] !== expected_pattern(exp_off_i[d], exp_ret_i[d])) begin
          $display("Mismatch %0s %0s_pwr expected %05b actual %05b", test_name_i,
                   domain_name(d), expected_pattern(exp_off_i[d], exp_ret_i[d]), dom_pwr_i[d]);
          mismatches++;
        end
      end
      if (rst_n_i !== exp_rst_n_i) begin
        $display("Mismatch %0s cpu/periph resets expected %02b actual %02b",
                 test_name_i, exp_rst_n_i, rst_n_i);
        mismatches++;
      end
    end
  end

  always @(negedge clk_i) begin
    for (int d = 0; d < NUM_DOM; d++) begin
      if (!rst_i) begin
        check_order(d, prev_q[d], dom_pwr_i[d]);
      end
      prev_q[d] = dom_pwr_i[d];
    end
  end

  assign mismatch_cnt_o = mismatches;
  assign rule_cnt_o = rule_errs;

endmodule

//--- testbench/tb_top.sv
/*
 * Testbench top: clock, reset, trace-driven stimulus,
 * power-switch acknowledge model, DUT and checker
 */
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import mcu_pkg::*;

  localparam int NUM_DOM = NUM_BANKS + 2;
  localparam int SETTLE_TIMEOUT = 200;

  logic clk_i = 1'b0;
  logic rst_i;
  logic debug_ndmreset_ni, core_sleep_i, cpu_pg_en_i, periph_off_i;
  logic irq_software_i, irq_external_i, timer0_intr_i, irq_ack_i;
  bank_mask_t bank_off_i, bank_ret_i;
  fast_intr_t fast_src_i, fast_en_i;
  irq_id_t irq_id_i;
  intr_t intr_o;
  logic cpu_rst_no, periph_rst_no;
  // index 0 cpu, 1 periph, 2 and up banks
  pwr_ctrl_out_t [NUM_DOM-1:0] dom_pwr_o;
  pwr_ctrl_in_t [NUM_DOM-1:0] dom_pwr_i;
  logic [2:0] ack_wait [NUM_DOM];
  int ack_delay;
  integer seed = 32'h398895d2;

  // stimulus fields of the current trace line
  logic t_ndm = 1'b1;
  logic t_sleep = 1'b0, t_pgen = 1'b0, t_poff = 1'b0;
  logic t_sw = 1'b0, t_ext = 1'b0, t_tmr = 1'b0, t_ack = 1'b0;
  bank_mask_t t_boff = '0, t_bret = '0;
  fast_intr_t t_src = '0, t_en = '0;
  irq_id_t t_id = '0;

  // expectations of the current step
  logic [8*20-1:0] step_name = '0;
  intr_t exp_intr = '0;
  logic exp_cpu_off = 1'b0, exp_periph_off = 1'b0;
  logic exp_cpu_rst = 1'b1, exp_periph_rst = 1'b1;
  bank_mask_t exp_bank_off = '0, exp_bank_ret = '0;

  logic check_stb;
  logic settled;
  int mismatch_cnt, rule_cnt;
  int steps = 0;
  int timeout_cnt = 0;
  int trace_errs = 0;

  always #2 clk_i = ~clk_i;

  mcu_ao_ctrl_top UUT (
    .clk_i,
    .rst_i,
    .debug_ndmreset_ni,
    .core_sleep_i,
    .cpu_pg_en_i,
    .periph_off_i,
    .bank_off_i,
    .bank_ret_i,
    .fast_src_i,
    .fast_en_i,
    .irq_software_i,
    .irq_external_i,
    .timer0_intr_i,
    .irq_ack_i,
    .irq_id_i,
    .intr_o,
    .cpu_pwr_o    (dom_pwr_o[0]),
    .periph_pwr_o (dom_pwr_o[1]),
    .cpu_pwr_i    (dom_pwr_i[0]),
    .periph_pwr_i (dom_pwr_i[1]),
    .bank_pwr_o   (dom_pwr_o[NUM_DOM-1:2]),
    .bank_pwr_i   (dom_pwr_i[NUM_DOM-1:2]),
    .cpu_rst_no,
    .periph_rst_no
  );

  tb_checker u_checker (
    .clk_i,
    .rst_i,
    .intr_i        (intr_o),
    .dom_pwr_i     (dom_pwr_o),
    .dom_ack_i     (dom_pwr_i),
    .rst_n_i       ({cpu_rst_no, periph_rst_no}),
    .check_i       (check_stb),
    .test_name_i   (step_name),
    .exp_intr_i    (exp_intr),
    .exp_off_i     ({exp_bank_off, exp_periph_off, exp_cpu_off}),
    .exp_ret_i     ({exp_bank_ret, 2'b00}),
    .exp_rst_n_i   ({exp_cpu_rst, exp_periph_rst}),
    .settled_o     (settled),
    .mismatch_cnt_o(mismatch_cnt),
    .rule_cnt_o    (rule_cnt)
  );

  // switch model copies the enable onto the ack after 1 to 4 cycles
  always @(posedge clk_i) begin
    for (int d = 0; d < NUM_DOM; d++) begin
      if (rst_i) begin
        dom_pwr_i[d].pwrgate_ack_n <= 1'b1;
        ack_wait[d] <= '0;
      end else if (dom_pwr_i[d].pwrgate_ack_n == dom_pwr_o[d].pwrgate_en_n) begin
        ack_wait[d] <= '0;
      end else if (ack_wait[d] == 0) begin
        ack_delay = 1 + {$random(seed)} % 4;
        if (ack_delay == 1) begin
          dom_pwr_i[d].pwrgate_ack_n <= dom_pwr_o[d].pwrgate_en_n;
        end else begin
          ack_wait[d] <= 3'(ack_delay - 1);
        end
      end else if (ack_wait[d] == 1) begin
        dom_pwr_i[d].pwrgate_ack_n <= dom_pwr_o[d].pwrgate_en_n;
      end else begin
        ack_wait[d] <= ack_wait[d] - 1;
      end
    end
  end

  task automatic apply_stimulus();
    debug_ndmreset_ni <= t_ndm;
    core_sleep_i <= t_sleep;
    cpu_pg_en_i <= t_pgen;
    periph_off_i <= t_poff;
    bank_off_i <= t_boff;
    bank_ret_i <= t_bret;
    fast_src_i <= t_src;
    fast_en_i <= t_en;
    irq_software_i <= t_sw;
    irq_external_i <= t_ext;
    timer0_intr_i <= t_tmr;
    irq_ack_i <= t_ack;
    irq_id_i <= t_id;
  endtask

  task automatic run_step();
    int waited;
    @(posedge clk_i);
    apply_stimulus();
    // ack is a single-cycle pulse
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!settled && waited < SETTLE_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!settled) begin
      $display("timeout: in step %0s the power domains did not settle within %0d cycles",
               step_name, SETTLE_TIMEOUT);
      timeout_cnt++;
    end
    @(posedge clk_i);
    check_stb <= 1'b1;
    @(posedge clk_i);
    check_stb <= 1'b0;
    steps++;
  endtask

  task automatic replay_trace();
    int fd;
    int n;
    string line;
    fd = $fopen("testbench/mcu_trace.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open the trace file testbench/mcu_trace.txt");
      trace_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %b %b %b %b %h %h %h %h %b %b %b %b %d %h %b %b %h %h %b %b",
                    step_name, t_ndm, t_sleep, t_pgen, t_poff, t_boff, t_bret, t_src, t_en,
                    t_sw, t_ext, t_tmr, t_ack, t_id, exp_intr, exp_cpu_off, exp_periph_off,
                    exp_bank_off, exp_bank_ret, exp_cpu_rst, exp_periph_rst);
        if (n != 21) begin
          $display("error: malformed trace line, %0d fields read: %s", n, line);
          trace_errs++;
        end else begin
          run_step();
        end
      end
    end
    $fclose(fd);
    if (steps == 0) begin
      $display("error: the trace file held no steps");
      trace_errs++;
    end
  endtask

  initial begin
    rst_i = 1'b1;
    check_stb = 1'b0;
    dom_pwr_i = '1;
    apply_stimulus();
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    replay_trace();
    $display("steps=%0d mismatches=%0d rule_errors=%0d timeouts=%0d trace_errors=%0d",
             steps, mismatch_cnt, rule_cnt, timeout_cnt, trace_errs);
    if (mismatch_cnt == 0 && rule_cnt == 0 && timeout_cnt == 0 && trace_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/mcu_trace.txt
# name ndm sleep pgen poff bank_off bank_ret fast_src fast_en sw ext tmr ack id(dec)
#   then expected: intr cpu_off periph_off bank_off bank_ret cpu_rst_n periph_rst_n
reset_idle       1 0 0 0 00 00 0000 0000 0 0 0 0 0  00000000 0 0 00 00 1 1
fast_disabled    1 0 0 0 00 00 0001 0000 0 0 0 0 0  00000000 0 0 00 00 1 1
fast_enabled     1 0 0 0 00 00 0001 0001 0 0 0 0 0  00010000 0 0 00 00 1 1
fast_ack_held    1 0 0 0 00 00 0001 0001 0 0 0 1 16 00010000 0 0 00 00 1 1
fast_ack_clear   1 0 0 0 00 00 0000 0001 0 0 0 1 16 00000000 0 0 00 00 1 1
fast_gpio        1 0 0 0 00 00 0100 7fff 0 0 0 0 0  01000000 0 0 00 00 1 1
fast_gpio_clear  1 0 0 0 00 00 0000 7fff 0 0 0 1 24 00000000 0 0 00 00 1 1
std_levels       1 0 0 0 00 00 4000 7fff 1 1 1 0 0  40000888 0 0 00 00 1 1
std_clear        1 0 0 0 00 00 0000 7fff 0 0 0 1 30 00000000 0 0 00 00 1 1
periph_off       1 0 0 1 00 00 0000 7fff 0 0 0 0 0  00000000 0 1 00 00 1 0
periph_on        1 0 0 0 00 00 0000 7fff 0 0 0 0 0  00000000 0 0 00 00 1 1
bank_retain      1 0 0 0 05 05 0000 7fff 0 0 0 0 0  00000000 0 0 00 05 1 1
bank_wake        1 0 0 0 00 05 0000 7fff 0 0 0 0 0  00000000 0 0 00 00 1 1
bank_off         1 0 0 0 05 00 0000 7fff 0 0 0 0 0  00000000 0 0 05 00 1 1
bank_mixed       1 0 0 0 f0 30 0000 7fff 0 0 0 0 0  00000000 0 0 c0 30 1 1
bank_restore     1 0 0 0 00 00 0000 7fff 0 0 0 0 0  00000000 0 0 00 00 1 1
cpu_sleep        1 1 1 0 00 00 0000 7fff 0 0 0 0 0  00000000 1 0 00 00 0 1
cpu_wake_fast    1 1 1 0 00 00 0002 7fff 0 0 0 0 0  00020000 0 0 00 00 1 1
cpu_resleep      1 1 1 0 00 00 0000 7fff 0 0 0 1 17 00000000 1 0 00 00 0 1
cpu_wake_sw      1 1 1 0 00 00 0000 7fff 1 0 0 0 0  00000008 0 0 00 00 1 1
cpu_awake        1 0 0 0 00 00 0000 7fff 0 0 0 0 0  00000000 0 0 00 00 1 1
periph_and_banks 1 0 0 1 ff 0f 0000 7fff 0 0 0 0 0  00000000 0 1 f0 0f 1 0
all_on           1 0 0 0 00 00 0000 7fff 0 0 0 0 0  00000000 0 0 00 00 1 1
ndm_reset        0 0 0 0 00 00 0000 7fff 0 0 0 0 0  00000000 0 0 00 00 0 0
ndm_release      1 0 0 0 00 00 0000 7fff 0 0 0 0 0  00000000 0 0 00 00 1 1

//--- build.f
design/mcu_pkg.sv
design/pwr_domain_fsm.sv
design/fast_irq_ctrl.sv
design/pwr_manager.sv
design/mcu_ao_ctrl_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv
